// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // data words and addresses share one width.
    typedef logic [31:0] u32_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    // instruction layout: opcode in 31:26, rk 14:10, rj 9:5, rd 4:0.
    localparam int OPC_LSB    = 26;
    localparam int IMM12_LSB  = 10; // ADDI immediate, sign extended.
    localparam int OFFS16_LSB = 10; // branch word offset, sign extended.

    // 3R operations, rd = rj op rk.
    localparam logic [5:0] OP_ADD  = 6'h01;
    localparam logic [5:0] OP_SUB  = 6'h02;
    localparam logic [5:0] OP_AND  = 6'h03;
    localparam logic [5:0] OP_OR   = 6'h04;
    localparam logic [5:0] OP_XOR  = 6'h05;

    // register plus immediate.
    localparam logic [5:0] OP_ADDI = 6'h0a;

    // branches compare rj with rd and jump to pc + offs16 * 4.
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BNE  = 6'h17;

endpackage

`default_nettype wire

// File: hdl/fetch_unit.sv
`default_nettype none

module fetch_unit import cpu_pkg::*; #(
    parameter u32_t RESET_PC = 32'h1c00_0000,
    parameter int   IQ_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic                      icache_req,
    output u32_t                      icache_pa,
    input  logic                      icache_busy,
    input  inst_t                     icache_data,
    input  logic                      icache_data_valid,
    input  logic [$clog2(IQ_DEPTH):0] count,
    input  logic                      flush,
    input  u32_t                      redirect_pc,
    output logic                      push,
    output u32_t                      push_pc,
    output inst_t                     push_inst
);
    localparam int AW = $clog2(IQ_DEPTH);

    u32_t          pc;
    u32_t          pend_pc;
    u32_t          addr_q [IQ_DEPTH];
    logic          run;
    logic          pend;
    logic [AW:0]   out_cnt;
    logic [AW:0]   out_cnt_nxt;
    logic [AW:0]   drop_cnt;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          accept;
    logic          hold;
    logic          credit_ok;
    logic          dropping;

    // every request in flight must have a guaranteed slot in the queue.
    assign credit_ok = ({1'b0, out_cnt} + {1'b0, count}) < (AW + 2)'(IQ_DEPTH);

    assign icache_req = run & credit_ok;
    assign icache_pa  = pc;
    assign accept     = icache_req & ~icache_busy;
    assign hold       = icache_req & icache_busy;

    assign dropping  = drop_cnt != '0;
    assign push      = icache_data_valid & ~dropping;
    assign push_pc   = addr_q[rd_ptr]; // responses come back in request order.
    assign push_inst = icache_data;

    assign out_cnt_nxt = out_cnt + (AW + 1)'(accept) - (AW + 1)'(icache_data_valid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run      <= 1'b0;
            pc       <= RESET_PC;
            pend     <= 1'b0;
            out_cnt  <= '0;
            drop_cnt <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end else begin
            run     <= 1'b1;
            out_cnt <= out_cnt_nxt;
            if (accept)
                wr_ptr <= wr_ptr + 1'b1;
            if (icache_data_valid)
                rd_ptr <= rd_ptr + 1'b1;
            if (flush) begin
                // everything still in flight after this edge is wrong path.
                drop_cnt <= out_cnt_nxt;
                // a request held by busy must stay on the port, so the jump waits.
                pend <= hold;
                if (!hold)
                    pc <= redirect_pc;
            end else begin
                drop_cnt <= drop_cnt - (AW + 1)'(icache_data_valid & dropping)
                          + (AW + 1)'(accept & pend);
                if (accept) begin
                    pc   <= pend ? pend_pc : pc + 32'd4;
                    pend <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush)
            pend_pc <= redirect_pc;
        if (accept)
            addr_q[wr_ptr] <= pc;
    end

endmodule

`default_nettype wire

// File: hdl/inst_queue.sv
`default_nettype none

module inst_queue import cpu_pkg::*; #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      push,
    input  u32_t                      push_pc,
    input  inst_t                     push_inst,
    input  logic                      pop,
    output logic                      head_valid,
    output u32_t                      head_pc,
    output inst_t                     head_inst,
    output logic [$clog2(IQ_DEPTH):0] count
);
    localparam int AW = $clog2(IQ_DEPTH);

    u32_t          pc_mem   [IQ_DEPTH];
    inst_t         inst_mem [IQ_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   cnt;
    logic          do_pop;

    assign do_pop     = pop & head_valid;
    assign head_valid = cnt != '0;
    assign head_pc    = pc_mem[rd_ptr];
    assign head_inst  = inst_mem[rd_ptr];
    assign count      = cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else if (flush) begin
            wr_ptr <= '0; // a flush drops any push in the same cycle.
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            cnt <= cnt + (AW + 1)'(push) - (AW + 1)'(do_pop);
        end
    end

    // fetch never pushes into a full queue, so no full check here.
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            pc_mem[wr_ptr]   <= push_pc;
            inst_mem[wr_ptr] <= push_inst;
        end
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rj,
    input  reg_idx_t rk_or_rd,
    output u32_t     rj_data,
    output u32_t     rk_or_rd_data,
    input  logic     we,
    input  reg_idx_t wr_idx,
    input  u32_t     wr_data
);

    u32_t regs [32];

    // r0 always reads as zero.
    assign rj_data       = (rj == '0) ? '0 : regs[rj];
    assign rk_or_rd_data = (rk_or_rd == '0) ? '0 : regs[rk_or_rd];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`default_nettype none

module exec_unit import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     head_valid,
    input  u32_t     head_pc,
    input  inst_t    head_inst,
    input  logic     trace_rdy,
    output logic     pop,
    output reg_idx_t rj,
    output reg_idx_t rk_or_rd,
    input  u32_t     rj_data,
    input  u32_t     rk_or_rd_data,
    output logic     we,
    output reg_idx_t wr_idx,
    output u32_t     wr_data,
    output logic     redirect,
    output u32_t     redirect_pc,
    output logic     debug_wb_valid,
    output u32_t     debug_wb_pc,
    output inst_t    debug_wb_inst,
    output logic     debug_wb_rf_wen,
    output reg_idx_t debug_wb_rf_wnum,
    output u32_t     debug_wb_rf_wdata
);

    logic [5:0] opc;
    reg_idx_t   rd;
    u32_t       imm_ext;
    u32_t       offs_ext;
    u32_t       alu_res;
    logic       alu_op;
    logic       is_br;
    logic       taken;
    logic       wen;

    assign opc      = head_inst[OPC_LSB +: 6];
    assign rd       = head_inst[4:0];
    assign rj       = head_inst[9:5];
    assign is_br    = (opc == OP_BEQ) || (opc == OP_BNE);
    assign rk_or_rd = is_br ? rd : head_inst[14:10]; // branches compare against rd.

    assign imm_ext  = {{20{head_inst[IMM12_LSB + 11]}}, head_inst[IMM12_LSB +: 12]};
    assign offs_ext = {{14{head_inst[OFFS16_LSB + 15]}}, head_inst[OFFS16_LSB +: 16], 2'b00};

    always_comb begin
        alu_op = 1'b1;
        case (opc)
            OP_ADD:  alu_res = rj_data + rk_or_rd_data;
            OP_SUB:  alu_res = rj_data - rk_or_rd_data;
            OP_AND:  alu_res = rj_data & rk_or_rd_data;
            OP_OR:   alu_res = rj_data | rk_or_rd_data;
            OP_XOR:  alu_res = rj_data ^ rk_or_rd_data;
            OP_ADDI: alu_res = rj_data + imm_ext;
            default: begin
                // branches and unknown opcodes write nothing.
                alu_res = '0;
                alu_op  = 1'b0;
            end
        endcase
    end

    assign taken = (opc == OP_BEQ) ? (rj_data == rk_or_rd_data) : (rj_data != rk_or_rd_data);
    assign wen   = alu_op && rd != '0;

    assign pop = head_valid & trace_rdy;

    // writeback happens on the pop edge.
    assign we      = pop & wen;
    assign wr_idx  = rd;
    assign wr_data = alu_res;

    assign redirect    = pop & is_br & taken;
    assign redirect_pc = head_pc + offs_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_wb_valid  <= 1'b0;
            debug_wb_rf_wen <= 1'b0;
        end else begin
            debug_wb_valid  <= pop;
            debug_wb_rf_wen <= pop & wen;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            debug_wb_pc       <= head_pc;
            debug_wb_inst     <= head_inst;
            debug_wb_rf_wnum  <= rd;
            debug_wb_rf_wdata <= alu_res;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter u32_t RESET_PC = 32'h1c00_0000,
    parameter int   IQ_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     trace_rdy,
    output logic     icache_req,
    output u32_t     icache_pa,
    input  logic     icache_busy,
    input  inst_t    icache_data,
    input  logic     icache_data_valid,
    output logic     debug_wb_valid,
    output u32_t     debug_wb_pc,
    output inst_t    debug_wb_inst,
    output logic     debug_wb_rf_wen,
    output reg_idx_t debug_wb_rf_wnum,
    output u32_t     debug_wb_rf_wdata
);

    logic [$clog2(IQ_DEPTH):0] count;
    logic     flush, redirect, push, pop, head_valid, we;
    u32_t     redirect_pc, push_pc, head_pc;
    inst_t    push_inst, head_inst;
    reg_idx_t rj, rk_or_rd, wr_idx;
    u32_t     rj_data, rk_or_rd_data, wr_data;

    assign flush = redirect; // a taken branch is the only source of a flush.

    fetch_unit #(.RESET_PC(RESET_PC), .IQ_DEPTH(IQ_DEPTH)) u_fetch (
        .clk, .rst_n,
        .icache_req, .icache_pa, .icache_busy, .icache_data, .icache_data_valid,
        .count, .flush, .redirect_pc,
        .push, .push_pc, .push_inst
    );

    inst_queue #(.IQ_DEPTH(IQ_DEPTH)) u_iq (
        .clk, .rst_n, .flush,
        .push, .push_pc, .push_inst,
        .pop,
        .head_valid, .head_pc, .head_inst, .count
    );

    reg_file u_rf (
        .clk, .rst_n,
        .rj, .rk_or_rd, .rj_data, .rk_or_rd_data,
        .we, .wr_idx, .wr_data
    );

    exec_unit u_exec (
        .clk, .rst_n,
        .head_valid, .head_pc, .head_inst, .trace_rdy,
        .pop,
        .rj, .rk_or_rd, .rj_data, .rk_or_rd_data,
        .we, .wr_idx, .wr_data,
        .redirect, .redirect_pc,
        .debug_wb_valid, .debug_wb_pc, .debug_wb_inst,
        .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

endmodule

`default_nettype wire

// File: verification/cpu_top_asserts.sv
`default_nettype none

module cpu_top_asserts import cpu_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     icache_req,
    input u32_t     icache_pa,
    input logic     icache_busy,
    input logic     redirect,
    input u32_t     redirect_pc,
    input logic     debug_wb_valid,
    input u32_t     debug_wb_pc,
    input logic     debug_wb_rf_wen,
    input reg_idx_t debug_wb_rf_wnum
);
    timeunit 1ns;
    timeprecision 1ps;

    logic br_pend;
    logic br_armed;
    u32_t pend_tgt;
    u32_t br_tgt;

    // a target takes effect only once its branch has shown on the trace.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            br_pend  <= 1'b0;
            br_armed <= 1'b0;
            pend_tgt <= '0;
            br_tgt   <= '0;
        end else begin
            br_pend <= redirect;
            if (redirect)
                pend_tgt <= redirect_pc;
            if (br_pend) begin
                br_tgt   <= pend_tgt; // the branch retires in this cycle.
                br_armed <= 1'b1;
            end else if (debug_wb_valid) begin
                br_armed <= 1'b0;
            end
        end
    end

    a_pa_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        icache_req |-> icache_pa[1:0] == 2'b00)
        else $error("icache_pa not word aligned");

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        icache_req && icache_busy |=> icache_req && $stable(icache_pa))
        else $error("request changed while busy");

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_rf_wen |-> debug_wb_rf_wnum != 5'd0)
        else $error("write enable reported for r0");

    a_branch_target: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_valid && br_armed |-> debug_wb_pc == br_tgt)
        else $error("retired pc after taken branch is not the target");

endmodule

bind cpu_top cpu_top_asserts u_asserts (.*);

`default_nettype wire

// File: verification/tb_cpu_top.sv
`default_nettype none

module tb_cpu_top;
    import cpu_pkg::*;

    timeunit 1ns;
    timeprecision 1ps;

    localparam u32_t RESET_PC = 32'h1c00_0000;
    localparam int   PROG_WORDS = 64;
    localparam int   N_STRAIGHT = 45;
    localparam int   N_R0 = 12;
    localparam int   N_BRANCH = 40;
    localparam int   N_RANDOM = 80;
    localparam int   N_BACKPRESSURE = 55;
    localparam int   N_TOTAL = N_STRAIGHT + N_R0 + N_BRANCH + N_RANDOM + N_BACKPRESSURE;
    // 200 cycles per retirement, plus room for five resets and the 50 cycle stall.
    localparam real  WATCHDOG_NS = (N_TOTAL * 200 + 5 * 20 + 50) * 10.0;

    logic     clk;
    logic     rst_n;
    logic     trace_rdy;
    logic     icache_req;
    u32_t     icache_pa;
    logic     icache_busy;
    inst_t    icache_data;
    logic     icache_data_valid;
    logic     debug_wb_valid;
    u32_t     debug_wb_pc;
    inst_t    debug_wb_inst;
    logic     debug_wb_rf_wen;
    reg_idx_t debug_wb_rf_wnum;
    u32_t     debug_wb_rf_wdata;

    inst_t prog [PROG_WORDS];
    int    prog_len;
    u32_t  ref_regs [32];
    u32_t  exp_pc;
    int    retired;
    logic  checking;
    logic  rnd_mode;
    logic  hold_rdy;
    string test_name;
    logic  first_req_done;
    u32_t  first_pa;

    u32_t  rsp_pa_q [$];
    int    rsp_due_q [$];
    int    cyc;

    cpu_top #(.RESET_PC(RESET_PC), .IQ_DEPTH(4)) i_cpu_top (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic inst_t enc_3r(logic [5:0] opc, reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        return {opc, 11'b0, rk, rj, rd};
    endfunction

    function automatic inst_t enc_addi(reg_idx_t rd, reg_idx_t rj, logic [11:0] imm);
        return {OP_ADDI, 4'b0, imm, rj, rd};
    endfunction

    function automatic inst_t enc_br(logic [5:0] opc, reg_idx_t rj, reg_idx_t rd, logic [15:0] offs);
        return {opc, offs, rj, rd};
    endfunction

    // words past the program read as unknown opcodes built from the address.
    function automatic inst_t mem_word(u32_t pa);
        u32_t idx;
        idx = (pa - RESET_PC) >> 2;
        if (pa >= RESET_PC && idx <= u32_t'(prog_len))
            return prog[idx];
        return {6'h3f, pa[25:0] ^ pa[31:6]};
    endfunction

    // applies one instruction of the ISA to the reference register state.
    function automatic void ref_step(input u32_t pc, input inst_t inst, output u32_t next_pc,
                                     output logic wen, output u32_t wdata);
        logic [5:0] opc;
        reg_idx_t   rd;
        u32_t       a;
        u32_t       b;
        u32_t       d;
        u32_t       imm;
        u32_t       offs;
        opc  = inst[31:26];
        rd   = inst[4:0];
        a    = ref_regs[inst[9:5]];
        b    = ref_regs[inst[14:10]];
        d    = ref_regs[rd];
        imm  = {{20{inst[21]}}, inst[21:10]};
        offs = {{14{inst[25]}}, inst[25:10], 2'b00};
        next_pc = pc + 32'd4;
        wen     = 1'b1;
        wdata   = '0;
        case (opc)
            OP_ADD:  wdata = a + b;
            OP_SUB:  wdata = a - b;
            OP_AND:  wdata = a & b;
            OP_OR:   wdata = a | b;
            OP_XOR:  wdata = a ^ b;
            OP_ADDI: wdata = a + imm;
            OP_BEQ: begin
                wen = 1'b0;
                if (a == d)
                    next_pc = pc + offs;
            end
            OP_BNE: begin
                wen = 1'b0;
                if (a != d)
                    next_pc = pc + offs;
            end
            default: wen = 1'b0;
        endcase
        if (rd == 5'd0)
            wen = 1'b0; // r0 never changes.
        if (wen)
            ref_regs[rd] = wdata;
    endfunction

    task automatic check(input string what, input u32_t exp, input u32_t act);
        if (exp !== act) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // the instruction memory raises busy at random and answers in order after 1 to 4 cycles.
    always begin
        int lat;
        @(negedge clk);
        if (!rst_n) begin
            rsp_pa_q.delete();
            rsp_due_q.delete();
        end else begin
            if (icache_req && !first_req_done) begin
                first_pa       = icache_pa;
                first_req_done = 1'b1;
            end
            if (icache_req && !icache_busy) begin
                lat = rnd_mode ? 1 + int'($urandom % 4) : 1;
                rsp_pa_q.push_back(icache_pa);
                rsp_due_q.push_back(cyc + lat);
            end
        end
        @(posedge clk);
        #1;
        cyc++;
        icache_data_valid = 1'b0;
        if (rst_n && rsp_pa_q.size() > 0 && rsp_due_q[0] <= cyc) begin
            icache_data_valid = 1'b1;
            icache_data       = mem_word(rsp_pa_q.pop_front());
            void'(rsp_due_q.pop_front());
        end
        icache_busy = rst_n && rnd_mode && ($urandom % 4 == 0);
    end

    always begin
        @(posedge clk);
        #1;
        if (hold_rdy)
            trace_rdy = 1'b0;
        else if (rnd_mode)
            trace_rdy = ($urandom % 3) != 0;
        else
            trace_rdy = 1'b1;
    end

    // compare each retirement with the reference model.
    always @(negedge clk) begin
        u32_t next_pc;
        logic wen;
        u32_t wdata;
        inst_t inst;
        if (checking && debug_wb_valid) begin
            inst = mem_word(exp_pc);
            check("pc", exp_pc, debug_wb_pc);
            check("inst", inst, debug_wb_inst);
            ref_step(exp_pc, inst, next_pc, wen, wdata);
            check("wen", u32_t'(wen), u32_t'(debug_wb_rf_wen));
            if (wen) begin
                check("wnum", u32_t'(inst[4:0]), u32_t'(debug_wb_rf_wnum));
                check("wdata", wdata, debug_wb_rf_wdata);
            end
            exp_pc = next_pc;
            retired++;
        end
    end

    initial begin
        #(WATCHDOG_NS * 1ns);
        $display("timeout: the expected retirements did not all arrive in time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic do_reset();
        checking = 1'b0;
        @(posedge clk);
        #1;
        rst_n          = 1'b0;
        first_req_done = 1'b0;
        exp_pc         = RESET_PC;
        retired        = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (16) begin
            @(negedge clk);
            check("req in reset", 32'd0, u32_t'(icache_req));
            check("valid in reset", 32'd0, u32_t'(debug_wb_valid));
            @(posedge clk);
            #1;
        end
        rst_n    = 1'b1;
        checking = 1'b1;
        @(negedge clk);
        check("req after reset", 32'd0, u32_t'(icache_req)); // first request comes one cycle later.
    endtask

    task automatic run_test(input string name, input int count);
        test_name = name;
        do_reset();
        wait (first_req_done);
        check("first pa", RESET_PC, first_pa);
        wait (retired >= count);
        checking = 1'b0;
    endtask

    task automatic gen_random(input int len, input logic with_br);
        int kind;
        for (int i = 0; i < len; i++) begin
            kind = int'($urandom % 8);
            if (with_br && kind < 2 && i + 4 < len)
                prog[i] = enc_br(kind == 0 ? OP_BEQ : OP_BNE, 5'($urandom % 4), 5'($urandom % 4),
                                 16'(1 + $urandom % 3));
            else if (kind < 5)
                prog[i] = enc_addi(5'($urandom % 8), 5'($urandom % 8), 12'($urandom));
            else
                prog[i] = enc_3r(6'(1 + $urandom % 5), 5'($urandom % 8), 5'($urandom % 8),
                                 5'($urandom % 8));
        end
        prog[len] = enc_br(OP_BEQ, 5'd0, 5'd0, 16'd0); // self loop ends every program.
        prog_len  = len;
    endtask

    initial begin
        int stop_at;
        rst_n             = 1'b0;
        trace_rdy         = 1'b1;
        icache_busy       = 1'b0;
        icache_data       = '0;
        icache_data_valid = 1'b0;
        checking          = 1'b0;
        rnd_mode          = 1'b0;
        hold_rdy          = 1'b0;
        cyc               = 0;
        prog_len          = 0;
        void'($urandom(32'h4601_6d04));

        gen_random(40, 1'b0);
        run_test("straight_line", N_STRAIGHT);

        prog[0] = enc_addi(5'd0, 5'd0, 12'd5);
        prog[1] = enc_3r(OP_ADD, 5'd1, 5'd0, 5'd0);
        prog[2] = enc_addi(5'd2, 5'd0, 12'hffd);
        prog[3] = enc_3r(OP_XOR, 5'd0, 5'd2, 5'd2);
        prog[4] = enc_3r(OP_OR, 5'd3, 5'd0, 5'd2);
        prog[5] = enc_3r(OP_SUB, 5'd0, 5'd3, 5'd2);
        prog[6] = enc_3r(OP_ADD, 5'd4, 5'd0, 5'd3);
        prog[7] = enc_br(OP_BEQ, 5'd0, 5'd0, 16'd0);
        prog_len = 7;
        run_test("r0_writes", N_R0);

        prog[0]  = enc_addi(5'd1, 5'd0, 12'd5);
        prog[1]  = enc_3r(OP_ADD, 5'd2, 5'd0, 5'd0);
        prog[2]  = enc_addi(5'd2, 5'd2, 12'd3);
        prog[3]  = enc_addi(5'd1, 5'd1, 12'hfff);
        prog[4]  = enc_br(OP_BNE, 5'd1, 5'd0, 16'hfffe); // backward loop
        prog[5]  = enc_br(OP_BEQ, 5'd1, 5'd0, 16'd2);
        prog[6]  = enc_addi(5'd3, 5'd0, 12'd99);          // skipped
        prog[7]  = enc_br(OP_BEQ, 5'd2, 5'd0, 16'd3);
        prog[8]  = enc_3r(OP_SUB, 5'd4, 5'd2, 5'd1);
        prog[9]  = enc_br(OP_BNE, 5'd4, 5'd2, 16'd2);
        prog[10] = enc_3r(OP_XOR, 5'd5, 5'd4, 5'd2);
        prog[11] = enc_br(OP_BEQ, 5'd0, 5'd0, 16'd0);
        prog_len = 11;
        run_test("branch_loop", N_BRANCH);

        rnd_mode = 1'b1;
        gen_random(60, 1'b1);
        run_test("random_stall", N_RANDOM);

        gen_random(50, 1'b0);
        test_name = "backpressure";
        do_reset();
        wait (retired >= 10);
        @(posedge clk);
        #1;
        hold_rdy = 1'b1;
        repeat (2) @(posedge clk);
        stop_at = retired;
        repeat (50) @(posedge clk);
        @(negedge clk);
        check("req with full queue", 32'd0, u32_t'(icache_req));
        check("retired while held", u32_t'(stop_at), u32_t'(retired));
        hold_rdy = 1'b0;
        wait (retired >= N_BACKPRESSURE);
        checking = 1'b0;

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/cpu_pkg.sv
hdl/fetch_unit.sv
hdl/inst_queue.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/cpu_top.sv
verification/cpu_top_asserts.sv
verification/tb_cpu_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_cpu_top -Mdir obj_dir
	./obj_dir/Vtb_cpu_top | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
